//--- sources.f
hw/rhd_pkg.sv
hw/rhd_phase_if.sv
hw/rhd_bit_timer.sv
hw/rhd_spi_shifter.sv
hw/rhd_frame_store.sv
hw/rhd_sequencer.sv
hw/rhd_recorder_top.sv
verification/rhd_headstage_model.sv
verification/tb_rhd_recorder.sv

//--- Bender.yml
package:
  name: rhd_recorder

sources:
  - files:
      - hw/rhd_pkg.sv
      - hw/rhd_phase_if.sv
      - hw/rhd_bit_timer.sv
      - hw/rhd_spi_shifter.sv
      - hw/rhd_frame_store.sv
      - hw/rhd_sequencer.sv
      - hw/rhd_recorder_top.sv
  - target: test
    files:
      - verification/rhd_headstage_model.sv
      - verification/tb_rhd_recorder.sv

//--- verification/tb_rhd_recorder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rhd_recorder import rhd_pkg::*; ();

    logic clk;
    logic rstn;
    logic record_start;
    logic busy;
    logic done;
    logic cs;
    logic sclk;
    logic mosi;
    wire [NUM_LINES-1:0] miso;
    stream_t rd_stream;
    chan_t rd_channel;
    sample_t rd_data;

    sample_t expect_tab [NUM_LINES][2][CHANNELS_PER_ADC];
    int errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;
    int done_count;
    int cs_fall_count;
    logic cs_prev;

    rhd_recorder_top DUT (
        .clk          (clk),
        .rstn         (rstn),
        .record_start (record_start),
        .busy         (busy),
        .done         (done),
        .cs           (cs),
        .sclk         (sclk),
        .mosi         (mosi),
        .miso         (miso),
        .rd_stream    (rd_stream),
        .rd_channel   (rd_channel),
        .rd_data      (rd_data)
    );

    rhd_headstage_model headstage (
        .cs   (cs),
        .sclk (sclk),
        .mosi (mosi),
        .miso (miso)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // count done pulses and chip select falls at the falling clock edge.
    always @(negedge clk) begin
        if (rstn) begin
            if (done) begin
                done_count = done_count + 1;
            end
            if (cs_prev && !cs) begin
                cs_fall_count = cs_fall_count + 1;
            end
        end
        cs_prev = cs;
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("FAILED at %0d ns: %s got %0h expected %0h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", tests_run, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic new_tables();
        sample_t value;
        for (int l = 0; l < NUM_LINES; l++) begin
            for (int s = 0; s < 2; s++) begin
                for (int c = 0; c < CHANNELS_PER_ADC; c++) begin
                    value = sample_t'($urandom);
                    expect_tab[l][s][c] = value;
                    headstage.set_sample(l, s, c, value);
                end
            end
        end
    endtask

    task automatic read_word(input int stream, input int chan, output sample_t data);
        @(negedge clk);
        rd_stream = stream_t'(stream);
        rd_channel = chan_t'(chan);
        #1;
        data = rd_data;
    endtask

    // stream index is line * 2 + side.
    task automatic check_frame(input string tag);
        sample_t data;
        for (int l = 0; l < NUM_LINES; l++) begin
            for (int s = 0; s < 2; s++) begin
                for (int c = 0; c < CHANNELS_PER_ADC; c++) begin
                    read_word(2 * l + s, c, data);
                    check_equal(data, expect_tab[l][s][c],
                                $sformatf("%s stream %0d channel %0d", tag, 2 * l + s, c));
                end
            end
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 6000) begin
                abort_run("timeout: done never came after record_start");
            end
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        record_start = 1'b1;
        @(negedge clk);
        record_start = 1'b0;
    endtask

    task automatic run_frame(input bit poke_while_busy, input string tag);
        int done_base;
        int falls_base;
        int falls_at_done;
        cmd_t expected;
        headstage.clear_log();
        done_base = done_count;
        falls_base = cs_fall_count;
        pulse_start();
        check_equal(busy, 1'b1, $sformatf("%s busy after record_start", tag));
        if (poke_while_busy) begin
            repeat (300) @(negedge clk);
            pulse_start();
        end
        wait_done();
        falls_at_done = cs_fall_count;
        repeat (8) @(negedge clk);
        check_equal(busy, 1'b0, $sformatf("%s busy after done", tag));
        check_equal(cs, 1'b1, $sformatf("%s cs after done", tag));
        check_equal(done_count - done_base, 1, $sformatf("%s done pulses", tag));
        check_equal(falls_at_done - falls_base, FRAME_TRANSFERS,
                    $sformatf("%s cs low periods", tag));
        check_equal(headstage.cmd_count, FRAME_TRANSFERS, $sformatf("%s transfers", tag));
        for (int i = 0; i < FRAME_TRANSFERS && i < headstage.cmd_count; i++) begin
            if (i < CHANNELS_PER_ADC) begin
                expected = {2'b00, chan_t'(i), 7'd0, 1'b1};
            end else begin
                expected = {2'b11, 6'd63, 8'd0};
            end
            check_equal(headstage.cmd_log[i], expected, $sformatf("%s command %0d", tag, i));
        end
    endtask

    initial begin
        sample_t data;
        void'($urandom(32'h38f));
        rstn = 1'b0;
        record_start = 1'b0;
        rd_stream = '0;
        rd_channel = '0;
        errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        tests_failed = 0;
        done_count = 0;
        cs_fall_count = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < 60; i++) begin
            @(negedge clk);
            check_equal(cs, 1'b1, "idle cs");
            check_equal(sclk, 1'b0, "idle sclk");
            check_equal(busy, 1'b0, "idle busy");
            check_equal(done, 1'b0, "idle done");
        end
        for (int s = 0; s < NUM_STREAMS; s++) begin
            for (int c = 0; c < CHANNELS_PER_ADC; c++) begin
                read_word(s, c, data);
                check_equal(data, 16'h0000, $sformatf("reset stream %0d channel %0d", s, c));
            end
        end
        end_test("idle after reset");

        new_tables();
        run_frame(1'b0, "frame 1");
        end_test("command sequence");

        check_frame("frame 1");
        end_test("frame data");

        for (int k = 0; k < 3; k++) begin
            new_tables();
            run_frame(1'b0, $sformatf("frame %0d", k + 2));
            check_frame($sformatf("frame %0d", k + 2));
        end
        end_test("frame replacement");

        new_tables();
        run_frame(1'b1, "frame 5");
        check_frame("frame 5");
        end_test("start while busy");

        $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/rhd_headstage_model.sv
`timescale 1ns/1ps
`default_nettype none

module rhd_headstage_model import rhd_pkg::*; (
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic [NUM_LINES-1:0] miso
);

    // sample tables per line, side (0 = a, 1 = b) and channel.
    sample_t samples [NUM_LINES][2][CHANNELS_PER_ADC];
    cmd_t cmd_log [64];
    int cmd_count;
    cmd_t rx_word;
    int rx_bits;
    cmd_t hist_1;
    cmd_t hist_2;
    sample_t ans_a [NUM_LINES];
    sample_t ans_b [NUM_LINES];

    task automatic set_sample(input int line, input int side, input int chan,
                              input sample_t value);
        samples[line][side][chan] = value;
    endtask

    task automatic clear_log();
        cmd_count = 0;
    endtask

    function automatic sample_t answer_for(input cmd_t cmd, input int line, input int side);
        if (cmd[15:14] == 2'b00 && cmd[13:8] < CHANNELS_PER_ADC) begin
            return samples[line][side][cmd[12:8]];
        end
        return sample_t'($urandom);
    endfunction

    // the chip latches mosi on the rising serial clock.
    always @(posedge sclk) begin
        if (cs === 1'b0) begin
            rx_word = {rx_word[BITS_PER_WORD-2:0], mosi};
            rx_bits = rx_bits + 1;
        end
    end

    always @(posedge cs) begin
        if (rx_bits == BITS_PER_WORD) begin
            hist_2 = hist_1;
            hist_1 = rx_word;
            if (cmd_count < 64) begin
                cmd_log[cmd_count] = rx_word;
            end
            cmd_count = cmd_count + 1;
        end
        rx_bits = 0;
    end

    // return path delay of 15 ns, between one clk period and one serial half period.
    initial begin
        cmd_count = 0;
        rx_bits = 0;
        rx_word = '0;
        hist_1 = '1;
        hist_2 = '1;
        miso = '0;
        forever begin
            @(negedge cs);
            for (int l = 0; l < NUM_LINES; l++) begin
                ans_a[l] = answer_for(hist_2, l, 0);
                ans_b[l] = answer_for(hist_2, l, 1);
            end
            #15;
            for (int l = 0; l < NUM_LINES; l++) begin
                miso[l] = ans_a[l][BITS_PER_WORD-1];
            end
            for (int b = BITS_PER_WORD - 1; b >= 0; b--) begin
                @(posedge sclk);
                #15;
                for (int l = 0; l < NUM_LINES; l++) begin
                    miso[l] = ans_b[l][b];
                end
                @(negedge sclk);
                if (b > 0) begin
                    #15;
                    for (int l = 0; l < NUM_LINES; l++) begin
                        miso[l] = ans_a[l][b-1];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rhd_recorder_top.sv
`timescale 1ns/1ps
`default_nettype none

module rhd_recorder_top import rhd_pkg::*; (
    input  logic clk,
    input  logic rstn,

    input  logic record_start,
    output logic busy,
    output logic done,

    output logic cs,
    output logic sclk,
    output logic mosi,
    input  logic [NUM_LINES-1:0] miso,

    input  stream_t rd_stream,
    input  chan_t rd_channel,
    output sample_t rd_data
);

    logic xfer_start;
    logic xfer_done;
    logic frame_start;
    logic word_valid;
    cmd_t cmd;
    sample_t [NUM_STREAMS-1:0] words;

    rhd_phase_if phase_bus ();

    rhd_sequencer u_sequencer (
        .clk          (clk),
        .rstn         (rstn),
        .record_start (record_start),
        .xfer_done    (xfer_done),
        .xfer_start   (xfer_start),
        .cmd          (cmd),
        .frame_start  (frame_start),
        .busy         (busy),
        .done         (done)
    );

    rhd_bit_timer u_bit_timer (
        .clk        (clk),
        .rstn       (rstn),
        .xfer_start (xfer_start),
        .xfer_done  (xfer_done),
        .cs         (cs),
        .sclk       (sclk),
        .phase      (phase_bus.timer)
    );

    // one shifter serves every return line.
    rhd_spi_shifter u_spi_shifter (
        .clk        (clk),
        .rstn       (rstn),
        .phase      (phase_bus.shifter),
        .cmd        (cmd),
        .xfer_done  (xfer_done),
        .miso       (miso),
        .mosi       (mosi),
        .word_valid (word_valid),
        .words      (words)
    );

    rhd_frame_store u_frame_store (
        .clk         (clk),
        .rstn        (rstn),
        .frame_start (frame_start),
        .word_valid  (word_valid),
        .words       (words),
        .rd_stream   (rd_stream),
        .rd_channel  (rd_channel),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

//--- hw/rhd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module rhd_sequencer import rhd_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic record_start,
    input  logic xfer_done,
    output logic xfer_start,
    output cmd_t cmd,
    output logic frame_start,
    output logic busy,
    output logic done
);

    seq_state_t state;
    chan_t xfer_idx;

    // convert for the channel transfers, identity read for the rest.
    function automatic cmd_t cmd_for(input chan_t idx);
        if (idx < CHANNELS_PER_ADC) begin
            return {CMD_CONVERT, idx, 7'd0, DSP_OFFSET_BIT};
        end
        return {CMD_READ, CHIP_ID_REG, 8'd0};
    endfunction

    // index only moves on entry to load, so the word is steady per transfer.
    assign cmd = cmd_for(xfer_idx);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            xfer_idx <= '0;
            xfer_start <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            xfer_start <= 1'b0;
            frame_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (record_start) begin
                        xfer_idx <= '0;
                        frame_start <= 1'b1;
                        state <= LOAD;
                    end
                end

                LOAD: begin
                    xfer_start <= 1'b1;
                    state <= SEND;
                end

                // timer takes the request this cycle.
                SEND: begin
                    state <= WAIT_XFER;
                end

                WAIT_XFER: begin
                    if (xfer_done) begin
                        if (xfer_idx == chan_t'(FRAME_TRANSFERS - 1)) begin
                            state <= FINISH;
                        end else begin
                            xfer_idx <= xfer_idx + 1'b1;
                            state <= LOAD;
                        end
                    end
                end

                FINISH: begin
                    state <= IDLE;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign busy = (state != IDLE);
    assign done = (state == FINISH);

endmodule

`default_nettype wire

//--- hw/rhd_frame_store.sv
`timescale 1ns/1ps
`default_nettype none

module rhd_frame_store import rhd_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic frame_start,
    input  logic word_valid,
    input  sample_t [NUM_STREAMS-1:0] words,
    input  stream_t rd_stream,
    input  chan_t rd_channel,
    output sample_t rd_data
);

    chan_t xfer_cnt;
    logic in_window;
    logic [CHAN_ADDR_W-1:0] wr_addr;
    sample_t mem [NUM_STREAMS][CHANNELS_PER_ADC];

    // the first returned words answer commands sent before the frame.
    assign in_window = (xfer_cnt >= CONVERT_DELAY) &&
                       (xfer_cnt < CONVERT_DELAY + CHANNELS_PER_ADC);
    assign wr_addr = CHAN_ADDR_W'(xfer_cnt - CONVERT_DELAY);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            xfer_cnt <= '0;
            for (int s = 0; s < NUM_STREAMS; s++) begin
                for (int c = 0; c < CHANNELS_PER_ADC; c++) begin
                    mem[s][c] <= '0;
                end
            end
        end else if (frame_start) begin
            xfer_cnt <= '0;
        end else if (word_valid) begin
            xfer_cnt <= xfer_cnt + 1'b1;
            if (in_window) begin
                for (int s = 0; s < NUM_STREAMS; s++) begin
                    mem[s][wr_addr] <= words[s];
                end
            end
        end
    end

    // channels past the converted range read as zero.
    assign rd_data = (rd_channel < CHANNELS_PER_ADC) ?
                     mem[rd_stream][rd_channel[CHAN_ADDR_W-1:0]] : '0;

endmodule

`default_nettype wire

//--- hw/rhd_spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module rhd_spi_shifter import rhd_pkg::*; (
    input  logic clk,
    input  logic rstn,
    rhd_phase_if.shifter phase,
    input  cmd_t cmd,
    input  logic xfer_done,
    input  logic [NUM_LINES-1:0] miso,
    output logic mosi,
    output logic word_valid,
    output sample_t [NUM_STREAMS-1:0] words
);

    cmd_t cmd_shift;
    sample_t [NUM_LINES-1:0] a_word;
    sample_t [NUM_LINES-1:0] b_word;

    // command goes out msb first.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cmd_shift <= '0;
        end else if (phase.load) begin
            cmd_shift <= cmd;
        end else if (phase.bit_start) begin
            cmd_shift <= {cmd_shift[BITS_PER_WORD-2:0], 1'b0};
        end
    end

    assign mosi = cmd_shift[BITS_PER_WORD-1];

    // the chip puts the a bit out on the fall, so it is stable at the rise.
    always_ff @(posedge clk) begin
        if (phase.sclk_rise) begin
            for (int l = 0; l < NUM_LINES; l++) begin
                a_word[l] <= {a_word[l][BITS_PER_WORD-2:0], miso[l]};
            end
        end
    end

    // and the b bit on the rise, taken at the fall.
    always_ff @(posedge clk) begin
        if (phase.sclk_fall) begin
            for (int l = 0; l < NUM_LINES; l++) begin
                b_word[l] <= {b_word[l][BITS_PER_WORD-2:0], miso[l]};
            end
        end
    end

    // stream index is line * 2 + edge.
    always_comb begin
        for (int l = 0; l < NUM_LINES; l++) begin
            words[2*l] = a_word[l];
            words[2*l+1] = b_word[l];
        end
    end

    // the last b bit was taken a cycle before done.
    assign word_valid = xfer_done;

endmodule

`default_nettype wire

//--- hw/rhd_bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module rhd_bit_timer import rhd_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic xfer_start,
    output logic xfer_done,
    output logic cs,
    output logic sclk,
    rhd_phase_if.timer phase
);

    logic run;
    logic tail;
    half_cnt_t half_cnt;
    bit_idx_t bit_cnt;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            run <= 1'b0;
            tail <= 1'b0;
            cs <= 1'b1;
            sclk <= 1'b0;
            half_cnt <= '0;
            bit_cnt <= '0;
            xfer_done <= 1'b0;
            phase.load <= 1'b0;
            phase.bit_start <= 1'b0;
            phase.sclk_rise <= 1'b0;
            phase.sclk_fall <= 1'b0;
        end else begin
            phase.load <= 1'b0;
            phase.bit_start <= 1'b0;
            phase.sclk_rise <= 1'b0;
            phase.sclk_fall <= 1'b0;
            // done follows the single cs-high cycle at the end.
            xfer_done <= tail;
            tail <= 1'b0;

            if (xfer_start && !run && !tail) begin
                run <= 1'b1;
                cs <= 1'b0;
                sclk <= 1'b0;
                half_cnt <= '0;
                bit_cnt <= '0;
                phase.load <= 1'b1;
            end else if (run) begin
                if (half_cnt == half_cnt_t'(HALF_BIT_CLKS - 1)) begin
                    half_cnt <= '0;
                    if (!sclk) begin
                        sclk <= 1'b1;
                        phase.sclk_rise <= 1'b1;
                    end else begin
                        sclk <= 1'b0;
                        phase.sclk_fall <= 1'b1;
                        if (bit_cnt == bit_idx_t'(BITS_PER_WORD - 1)) begin
                            // last bit finished, release the chips.
                            run <= 1'b0;
                            cs <= 1'b1;
                            tail <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            phase.bit_start <= 1'b1;
                        end
                    end
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rhd_phase_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rhd_phase_if;

    // command word capture, one cycle after the transfer request.
    logic load;
    // next command bit goes out.
    logic bit_start;
    // stream a sample point.
    logic sclk_rise;
    // stream b sample point.
    logic sclk_fall;

    modport timer (
        output load,
        output bit_start,
        output sclk_rise,
        output sclk_fall
    );

    modport shifter (
        input load,
        input bit_start,
        input sclk_rise,
        input sclk_fall
    );

endinterface

`default_nettype wire

//--- hw/rhd_pkg.sv
`default_nettype none

package rhd_pkg;

    // serial word format.
    localparam int BITS_PER_WORD = 16;
    localparam int HALF_BIT_CLKS = 2;

    // headstage geometry, two sample streams per return line.
    localparam int NUM_LINES = 2;
    localparam int NUM_STREAMS = 2 * NUM_LINES;
    localparam int CHANNELS_PER_ADC = 32;
    localparam int CHAN_ADDR_W = $clog2(CHANNELS_PER_ADC);

    // 32 converts followed by identity reads that flush the pipeline.
    localparam int FRAME_TRANSFERS = 40;
    localparam int CONVERT_DELAY = 2;

    localparam int HALF_CNT_W = (HALF_BIT_CLKS > 1) ? $clog2(HALF_BIT_CLKS) : 1;

    typedef logic [BITS_PER_WORD-1:0] sample_t;
    typedef logic [BITS_PER_WORD-1:0] cmd_t;
    typedef logic [5:0] chan_t;
    typedef logic [$clog2(NUM_STREAMS)-1:0] stream_t;
    typedef logic [$clog2(BITS_PER_WORD)-1:0] bit_idx_t;
    typedef logic [HALF_CNT_W-1:0] half_cnt_t;

    // command field codes, upper two bits of the word.
    localparam logic [1:0] CMD_CONVERT = 2'b00;
    localparam logic [1:0] CMD_READ = 2'b11;

    localparam chan_t CHIP_ID_REG = 6'd63;
    localparam logic DSP_OFFSET_BIT = 1'b1;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        SEND,
        WAIT_XFER,
        FINISH
    } seq_state_t;

endpackage

`default_nettype wire
